// ==== design/link_pkg.sv ====
package link_pkg;

    parameter int TYPE_W     = 4;
    parameter int CHK_W      = 4;
    parameter int PAYLOAD_W  = 32;
    // Start bit, type, payload, checksum and stop bit.
    parameter int FRAME_BITS = 1 + TYPE_W + PAYLOAD_W + CHK_W + 1;

    typedef enum logic [TYPE_W-1:0] {
        INIT   = 4'd0,
        ACK    = 4'd1,
        NAK    = 4'd2,
        STL    = 4'd3,
        DIDX   = 4'd5,
        DPARAM = 4'd6,
        DDIDX  = 4'd7,
        DLINK  = 4'd8,
        DTYPE  = 4'd9,
        DTEMP  = 4'd10,
        DATA0  = 4'd13,
        DATA1  = 4'd14,
        ERROR  = 4'd15       // Local marker for a damaged frame.
    } packet_type_e;

    typedef enum logic [3:0] {
        MAIN_IDLE, SEND_PREP, SEND_DATA, RANS_WAIT, RANS_TAKE, RANS_DONE,
        SEND_DONE, READ_PREP, READ_TAKE, WANS_PREP, WANS_SEND, READ_DONE
    } link_state_e;

    typedef enum logic [1:0] {
        NONE,
        OK,
        RETRY_EXHAUSTED,
        TIMED_OUT
    } send_status_e;

    // XOR of the type nibble and all payload nibbles.
    function automatic logic [CHK_W-1:0] frame_checksum(
        input logic [TYPE_W-1:0]    ptype,
        input logic [PAYLOAD_W-1:0] payload
    );
        logic [CHK_W-1:0] sum;
        sum = ptype;
        for (int i = 0; i < PAYLOAD_W / CHK_W; i++) begin
            sum = sum ^ payload[i*CHK_W +: CHK_W];
        end
        return sum;
    endfunction

endpackage

// ==== design/frame_tx.sv ====
`timescale 1ns/100ps

module frame_tx import link_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 tx_start,
    input  packet_type_e         tx_type,
    input  logic [PAYLOAD_W-1:0] tx_data,
    output logic                 tx_done,
    output logic                 tx_line
);

    localparam int CNT_W = $clog2(FRAME_BITS);

    logic [FRAME_BITS-1:0] frame;
    logic [FRAME_BITS-1:0] shift_reg;
    logic [CNT_W-1:0]      bit_cnt;
    logic                  busy;      // A frame is on the line.
    logic                  load;

    assign frame = {1'b0, tx_type, tx_data, frame_checksum(tx_type, tx_data), 1'b1};

    // No new frame until the previous request has been released.
    assign load = tx_start && !tx_done && !busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            tx_done <= 1'b0;
            tx_line <= 1'b1;
        end else if (load) begin
            busy    <= 1'b1;
            bit_cnt <= '0;
            tx_line <= frame[FRAME_BITS-1];    // Start bit.
        end else if (busy) begin
            if (bit_cnt == CNT_W'(FRAME_BITS - 1)) begin
                busy    <= 1'b0;
                tx_done <= 1'b1;
                tx_line <= 1'b1;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
                tx_line <= shift_reg[FRAME_BITS-2];
            end
        end else if (tx_done && !tx_start) begin
            tx_done <= 1'b0;
        end
    end

    // MSB first; idle ones fill in behind.
    always_ff @(posedge clk) begin
        if (load) begin
            shift_reg <= frame;
        end else if (busy) begin
            shift_reg <= {shift_reg[FRAME_BITS-2:0], 1'b1};
        end
    end

    a_idle_high: assert property (@(posedge clk) disable iff (rst) !busy |-> tx_line)
        else $error("tx_line low while no frame is shifted");

endmodule

// ==== design/frame_rx.sv ====
`timescale 1ns/100ps

module frame_rx import link_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rx_line,
    output logic                 rx_valid,
    output packet_type_e         rx_type,
    output logic [PAYLOAD_W-1:0] rx_data,
    input  logic                 rx_taken
);

    localparam int CNT_W  = $clog2(FRAME_BITS);
    localparam int BODY_W = FRAME_BITS - 2;    // Type, payload and checksum.

    logic [BODY_W-1:0]    shift_reg;
    logic [CNT_W-1:0]     bit_cnt;
    logic                 busy;
    logic                 last_bit;
    logic [TYPE_W-1:0]    got_type;
    logic [PAYLOAD_W-1:0] got_data;
    logic [CHK_W-1:0]     got_chk;
    logic                 frame_ok;

    assign got_type = shift_reg[BODY_W-1 -: TYPE_W];
    assign got_data = shift_reg[CHK_W +: PAYLOAD_W];
    assign got_chk  = shift_reg[CHK_W-1:0];
    assign last_bit = busy && (bit_cnt == CNT_W'(FRAME_BITS - 1));

    // The stop bit is still on the line during the last cycle.
    assign frame_ok = (frame_checksum(got_type, got_data) == got_chk) && rx_line;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else if (rx_valid) begin
            if (rx_taken) begin
                rx_valid <= 1'b0;
            end
        end else if (!busy) begin
            if (!rx_line) begin
                busy    <= 1'b1;               // Start bit seen.
                bit_cnt <= CNT_W'(1);
            end
        end else if (last_bit) begin
            busy     <= 1'b0;
            rx_valid <= 1'b1;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (busy && !last_bit) begin
            shift_reg <= {shift_reg[BODY_W-2:0], rx_line};
        end
        if (last_bit) begin
            rx_type <= frame_ok ? packet_type_e'(got_type) : ERROR;
            rx_data <= got_data;
        end
    end

    // Frame is held for the controller until it has been taken.
    a_hold_valid: assert property (@(posedge clk) disable iff (rst)
        $fell(rx_valid) |-> $past(rx_taken))
        else $error("rx_valid dropped without rx_taken");

endmodule

// ==== design/link_ctrl.sv ====
`timescale 1ns/100ps

module link_ctrl import link_pkg::*; #(
    parameter int TIMEOUT_CYCLES = 128,
    parameter int RETRY_LIMIT    = 16
) (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 send_req,
    input  packet_type_e         send_type,
    input  logic [PAYLOAD_W-1:0] send_data,
    output logic                 send_done,
    output send_status_e         send_status,

    output logic                 read_ready,
    output packet_type_e         read_type,
    output logic [PAYLOAD_W-1:0] read_data,
    input  logic                 read_ack,

    output logic                 tx_start,
    output packet_type_e         tx_type,
    output logic [PAYLOAD_W-1:0] tx_data,
    input  logic                 tx_done,

    input  logic                 rx_valid,
    input  packet_type_e         rx_type,
    input  logic [PAYLOAD_W-1:0] rx_data,
    output logic                 rx_taken
);

    localparam int WAIT_W = $clog2(TIMEOUT_CYCLES + 1);
    localparam int ANS_W  = $clog2(RETRY_LIMIT + 1);

    link_state_e       state, next_state;
    logic [WAIT_W-1:0] wait_cnt;
    logic [ANS_W-1:0]  ans_cnt;
    logic              resend;
    logic              timeout;
    logic              retry_last;

    assign timeout    = (wait_cnt == WAIT_W'(TIMEOUT_CYCLES - 1));
    assign retry_last = (ans_cnt == ANS_W'(RETRY_LIMIT - 1));

    assign send_done  = (state == SEND_DONE);
    assign read_ready = (state == READ_DONE);
    assign tx_start   = (state == SEND_DATA) || (state == WANS_SEND);
    assign rx_taken   = (state == RANS_DONE) || (state == READ_TAKE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= MAIN_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            MAIN_IDLE: begin
                if (send_req) begin
                    next_state = SEND_PREP;    // Sending wins over reading.
                end else if (rx_valid) begin
                    next_state = READ_PREP;
                end
            end
            SEND_PREP: next_state = SEND_DATA;
            SEND_DATA: begin
                if (tx_done) next_state = RANS_WAIT;
            end
            RANS_WAIT: begin
                if (timeout) begin
                    next_state = SEND_DONE;
                end else if (rx_valid) begin
                    next_state = RANS_TAKE;
                end
            end
            RANS_TAKE: next_state = RANS_DONE;
            RANS_DONE: begin
                if (!rx_valid) next_state = resend ? SEND_DATA : SEND_DONE;
            end
            SEND_DONE: begin
                if (!send_req) next_state = MAIN_IDLE;
            end
            READ_PREP: next_state = READ_TAKE;
            READ_TAKE: begin
                if (!rx_valid) next_state = WANS_PREP;
            end
            WANS_PREP: next_state = WANS_SEND;
            WANS_SEND: begin
                if (tx_done) next_state = READ_DONE;
            end
            READ_DONE: begin
                if (read_ack) next_state = MAIN_IDLE;
            end
            default: next_state = MAIN_IDLE;
        endcase
    end

    // Answer counting and the outcome of a send.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wait_cnt    <= '0;
            ans_cnt     <= '0;
            resend      <= 1'b0;
            send_status <= NONE;
        end else begin
            wait_cnt <= (state == RANS_WAIT) ? wait_cnt + 1'b1 : '0;
            case (state)
                SEND_PREP: begin
                    ans_cnt     <= '0;
                    send_status <= NONE;
                end
                RANS_WAIT: begin
                    if (timeout) send_status <= TIMED_OUT;
                end
                RANS_TAKE: begin
                    ans_cnt <= ans_cnt + 1'b1;
                    if (rx_type == ACK) begin
                        resend      <= 1'b0;
                        send_status <= OK;
                    end else if (retry_last) begin
                        resend      <= 1'b0;
                        send_status <= RETRY_EXHAUSTED;
                    end else begin
                        resend <= 1'b1;          // Anything but ACK is a NAK.
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == SEND_PREP) begin
            tx_type <= send_type;
            tx_data <= send_data;
        end else if (state == WANS_PREP) begin
            tx_type <= (read_type == ERROR) ? NAK : ACK;
            tx_data <= '0;
        end
        if (state == READ_PREP) begin
            read_type <= rx_type;
            read_data <= rx_data;
        end
    end

    // A finished send always carries its outcome.
    a_done_status: assert property (@(posedge clk) disable iff (rst)
        send_done |-> (send_status != NONE))
        else $error("send_done raised without a send status");

endmodule

// ==== design/link_node.sv ====
`timescale 1ns/100ps

module link_node import link_pkg::*; #(
    parameter int TIMEOUT_CYCLES = 128,
    parameter int RETRY_LIMIT    = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 send_req,
    input  packet_type_e         send_type,
    input  logic [PAYLOAD_W-1:0] send_data,
    output logic                 send_done,
    output send_status_e         send_status,
    output logic                 read_ready,
    output packet_type_e         read_type,
    output logic [PAYLOAD_W-1:0] read_data,
    input  logic                 read_ack,
    output logic                 tx_line,
    input  logic                 rx_line
);

    logic                 tx_start;
    logic                 tx_done;
    packet_type_e         tx_type;
    logic [PAYLOAD_W-1:0] tx_data;
    logic                 rx_valid;
    logic                 rx_taken;
    packet_type_e         rx_type;
    logic [PAYLOAD_W-1:0] rx_data;

    link_ctrl #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES),
        .RETRY_LIMIT    (RETRY_LIMIT)
    ) ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .send_req    (send_req),
        .send_type   (send_type),
        .send_data   (send_data),
        .send_done   (send_done),
        .send_status (send_status),
        .read_ready  (read_ready),
        .read_type   (read_type),
        .read_data   (read_data),
        .read_ack    (read_ack),
        .tx_start    (tx_start),
        .tx_type     (tx_type),
        .tx_data     (tx_data),
        .tx_done     (tx_done),
        .rx_valid    (rx_valid),
        .rx_type     (rx_type),
        .rx_data     (rx_data),
        .rx_taken    (rx_taken)
    );

    frame_tx tx_i (
        .clk      (clk),
        .rst      (rst),
        .tx_start (tx_start),
        .tx_type  (tx_type),
        .tx_data  (tx_data),
        .tx_done  (tx_done),
        .tx_line  (tx_line)
    );

    frame_rx rx_i (
        .clk      (clk),
        .rst      (rst),
        .rx_line  (rx_line),
        .rx_valid (rx_valid),
        .rx_type  (rx_type),
        .rx_data  (rx_data),
        .rx_taken (rx_taken)
    );

endmodule

// ==== sim/link_checker.sv ====
`timescale 1ns/100ps

module link_checker import link_pkg::*; #(
    parameter int RETRY_LIMIT = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 send_req,
    input  packet_type_e         send_type,
    input  logic [PAYLOAD_W-1:0] send_data,
    input  logic                 send_done,
    input  send_status_e         send_status,
    input  logic                 read_ready,
    input  packet_type_e         read_type,
    input  logic [PAYLOAD_W-1:0] read_data,
    input  logic                 tx_line,
    input  logic                 rx_line,
    input  int                   trial_kind,    // 0 send, 1 silent peer, 2 incoming.
    input  int                   nak_count,
    input  int                   timeouts,
    input  logic                 run_end,
    output int                   errors
);

    int                    checks = 0;
    int                    err_cnt = 0;
    int                    tx_cnt = 0;
    int                    rx_cnt = 0;
    int                    frames = 0;      // DUT frames in the current trial.
    logic [FRAME_BITS-1:0] tx_bits = '1;
    logic [FRAME_BITS-1:0] rx_bits = '1;
    logic                  rx_good = 1'b1;
    logic                  rst_q = 1'b0;
    logic                  req_q = 1'b0;
    logic                  done_q = 1'b0;
    logic                  ready_q = 1'b0;

    assign errors = err_cnt;

    // Nibble XOR over type and payload.
    function automatic logic [3:0] nibble_xor(input logic [35:0] tp);
        logic [3:0] s;
        s = 4'h0;
        for (int i = 0; i < 9; i++) begin
            s = s ^ tp[i*4 +: 4];
        end
        return s;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            err_cnt++;
            $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    // Start bit stripped. Type [40:37], payload [36:5], checksum [4:1], stop [0].
    task automatic check_tx_frame(input logic [FRAME_BITS-2:0] f);
        frames++;
        check_value("tx stop bit", 32'd1, 32'(f[0]));
        check_value("tx checksum", 32'(nibble_xor(f[40:5])), 32'(f[4:1]));
        if (trial_kind == 2) begin
            check_value("answer type", rx_good ? 32'(ACK) : 32'(NAK), 32'(f[40:37]));
            check_value("answer payload", 32'h0, f[36:5]);
        end else begin
            check_value("send frame type", 32'(send_type), 32'(f[40:37]));
            check_value("send frame payload", send_data, f[36:5]);
        end
    endtask

    task automatic check_send_end();
        int exp_frames;
        exp_frames = (nak_count + 1 < RETRY_LIMIT) ? nak_count + 1 : RETRY_LIMIT;
        if (trial_kind == 1) begin
            check_value("silent peer frames", 32'd1, 32'(frames));
            check_value("silent peer status", 32'(TIMED_OUT), 32'(send_status));
        end else begin
            check_value("retry frames", 32'(exp_frames), 32'(frames));
            check_value("retry status", (nak_count < RETRY_LIMIT) ? 32'(OK)
                        : 32'(RETRY_EXHAUSTED), 32'(send_status));
        end
    endtask

    task automatic check_read();
        check_value("answer frames", 32'd1, 32'(frames));
        check_value("read type", rx_good ? 32'(rx_bits[40:37]) : 32'(ERROR), 32'(read_type));
        if (rx_good) begin
            check_value("read data", rx_bits[36:5], read_data);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            tx_cnt = 0;
            rx_cnt = 0;
        end else begin
            if (rst_q) begin                     // First edge out of reset.
                check_value("reset send_done", 32'd0, 32'(send_done));
                check_value("reset read_ready", 32'd0, 32'(read_ready));
                check_value("reset send_status", 32'(NONE), 32'(send_status));
                check_value("reset tx_line", 32'd1, 32'(tx_line));
            end
            if (send_req && !req_q) frames = 0;
            if (tx_cnt > 0) begin
                tx_bits = {tx_bits[FRAME_BITS-2:0], tx_line};
                tx_cnt++;
                if (tx_cnt == FRAME_BITS) begin
                    tx_cnt = 0;
                    check_tx_frame(tx_bits[FRAME_BITS-2:0]);
                end
            end else if (!tx_line) begin
                tx_cnt = 1;
            end
            if (rx_cnt > 0) begin
                rx_bits = {rx_bits[FRAME_BITS-2:0], rx_line};
                rx_cnt++;
                if (rx_cnt == FRAME_BITS) begin
                    rx_cnt = 0;
                    rx_good = (nibble_xor(rx_bits[40:5]) == rx_bits[4:1]) && rx_bits[0];
                    if (trial_kind == 2) frames = 0;
                end
            end else if (!rx_line) begin
                rx_cnt = 1;
            end
            if (send_done && !done_q) check_send_end();
            if (read_ready && !ready_q) check_read();
        end
        rst_q = rst;
        req_q = send_req;
        done_q = send_done;
        ready_q = read_ready;
    end

    always @(posedge run_end) begin
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, err_cnt, timeouts);
    end

endmodule

// ==== sim/tb_link_node.sv ====
`timescale 1ns/100ps

module tb_link_node import link_pkg::*; ();

    localparam int RETRY_LIMIT    = 4;
    localparam int TIMEOUT_CYCLES = 128;
    localparam int TRIALS         = 40;
    localparam int WAIT_LIMIT     = 400;    // Cycles allowed per wait.

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  send_req;
    packet_type_e          send_type;
    logic [PAYLOAD_W-1:0]  send_data;
    logic                  send_done;
    send_status_e          send_status;
    logic                  read_ready;
    packet_type_e          read_type;
    logic [PAYLOAD_W-1:0]  read_data;
    logic                  read_ack;
    logic                  tx_line;
    logic                  rx_line;
    int                    trial_kind;
    int                    nak_count;
    int                    timeouts;
    int                    errors;
    int                    handled;
    logic                  run_end;
    int                    dec_cnt = 0;
    logic [FRAME_BITS-1:0] dec_bits = '1;
    packet_type_e          tx_q[$];             // Frames the peer has seen.
    packet_type_e          codes [12] = '{INIT, ACK, NAK, STL, DIDX, DPARAM, DDIDX, DLINK,
                                          DTYPE, DTEMP, DATA0, DATA1};

    always #20 clk = ~clk;

    link_node #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES),
        .RETRY_LIMIT    (RETRY_LIMIT)
    ) dut_i (
        .clk (clk), .rst (rst), .send_req (send_req), .send_type (send_type),
        .send_data (send_data), .send_done (send_done), .send_status (send_status),
        .read_ready (read_ready), .read_type (read_type), .read_data (read_data),
        .read_ack (read_ack), .tx_line (tx_line), .rx_line (rx_line)
    );

    link_checker #(.RETRY_LIMIT (RETRY_LIMIT)) chk_i (
        .clk (clk), .rst (rst), .send_req (send_req), .send_type (send_type),
        .send_data (send_data), .send_done (send_done), .send_status (send_status),
        .read_ready (read_ready), .read_type (read_type), .read_data (read_data),
        .tx_line (tx_line), .rx_line (rx_line), .trial_kind (trial_kind),
        .nak_count (nak_count), .timeouts (timeouts), .run_end (run_end), .errors (errors)
    );

    // Peer receiver that decodes the type of each frame on tx_line.
    always @(posedge clk) begin
        if (rst) begin
            dec_cnt = 0;
        end else if (dec_cnt > 0) begin
            dec_bits = {dec_bits[FRAME_BITS-2:0], tx_line};
            dec_cnt++;
            if (dec_cnt == FRAME_BITS) begin
                dec_cnt = 0;
                tx_q.push_back(packet_type_e'(dec_bits[40:37]));
            end
        end else if (!tx_line) begin
            dec_cnt = 1;
        end
    end

    function automatic logic [3:0] nibble_xor(input logic [35:0] tp);
        logic [3:0] s;
        s = 4'h0;
        for (int i = 0; i < 9; i++) begin
            s = s ^ tp[i*4 +: 4];
        end
        return s;
    endfunction

    function automatic packet_type_e pick_type();
        logic [3:0] idx;
        idx = 4'($urandom % 12);
        return codes[idx];
    endfunction

    task automatic note_timeout(input string what);
        $display("Timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
        timeouts++;
    endtask

    // Peer transmitter. A nonzero flip inverts that bit, counted from the start bit.
    task automatic drive_frame(input packet_type_e ptype, input logic [31:0] payload,
                               input int flip);
        logic [FRAME_BITS-1:0] bits;
        bits = {1'b0, ptype, payload, nibble_xor({ptype, payload}), 1'b1};
        if (flip > 0) bits[FRAME_BITS-1-flip] = ~bits[FRAME_BITS-1-flip];
        for (int i = FRAME_BITS - 1; i >= 0; i--) begin
            @(posedge clk);
            #2 rx_line = bits[i];
        end
        @(posedge clk);
        #2 rx_line = 1'b1;
    endtask

    task automatic send_trial(input bit silent, input int k);
        int naks;
        int cycles;
        naks = k;
        trial_kind = silent ? 1 : 0;
        nak_count = k;
        handled = tx_q.size();
        send_type = pick_type();
        send_data = $urandom;
        send_req = 1'b1;
        cycles = 0;
        while (!send_done && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #2 cycles++;
            if (!silent && tx_q.size() > handled) begin
                handled++;
                repeat (3) @(posedge clk);   // Peer answer delay.
                drive_frame((naks > 0) ? NAK : ACK, 32'h0, 0);
                if (naks > 0) naks--;
                cycles = 0;
            end
        end
        if (!send_done) note_timeout("send_done");
        send_req = 1'b0;
        cycles = 0;
        while (send_done && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #2 cycles++;
        end
        if (send_done) note_timeout("release of send_done");
    endtask

    task automatic receive_trial();
        int flip;
        int cycles;
        flip = 0;
        if ($urandom % 3 == 0) flip = 1 + $urandom % (FRAME_BITS - 1);
        trial_kind = 2;
        drive_frame(pick_type(), $urandom, flip);
        cycles = 0;
        while (!read_ready && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #2 cycles++;
        end
        if (!read_ready) note_timeout("read_ready");
        read_ack = 1'b1;
        cycles = 0;
        while (read_ready && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #2 cycles++;
        end
        if (read_ready) note_timeout("release of read_ready");
        read_ack = 1'b0;
    endtask

    initial begin
        int kind;
        int k;
        void'($urandom(50));
        rst = 1'b1;
        send_req = 1'b0;
        send_type = INIT;
        send_data = '0;
        read_ack = 1'b0;
        rx_line = 1'b1;
        trial_kind = 0;
        nak_count = 0;
        timeouts = 0;
        handled = 0;
        run_end = 1'b0;
        repeat (4) @(posedge clk);
        #2 rst = 1'b0;
        for (int t = 0; t < TRIALS && timeouts == 0; t++) begin
            kind = $urandom % 3;
            k = $urandom % 7;
            if (kind == 2) begin
                receive_trial();
            end else begin
                send_trial(kind == 1, k);
            end
            repeat (4) @(posedge clk);
            #2;
        end
        run_end = 1'b1;
        #1;
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== project.f ====
design/link_pkg.sv
design/frame_tx.sv
design/frame_rx.sv
design/link_ctrl.sv
design/link_node.sv
sim/link_checker.sv
sim/tb_link_node.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the link node testbench with Verilator.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
        --top-module tb_link_node -Mdir obj_dir -o tb_link_node -f project.f; then
    echo "Build failed"
    exit 1
fi

if ! ./obj_dir/tb_link_node > sim.log 2>&1; then
    cat sim.log
    echo "Simulation run returned an error"
    exit 1
fi
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    echo "Result: pass"
    exit 0
fi
echo "Result: fail"
exit 1
